/* common/tinker_pkg.sv */
// Shared types, opcodes, field positions and opcode classes; imported by every core module
package tinker_pkg;

    localparam int XLEN = 64;                        // Data and address width

    typedef logic [XLEN-1:0] word_t;                 // Register or address value
    typedef logic [31:0]     instr_t;                // Fetched instruction word
    typedef logic [4:0]      reg_addr_t;             // Register index

    // ----------------------------------------------------------
    // Instruction encoding
    // ----------------------------------------------------------
    typedef enum logic [4:0] {
        op_and     = 5'b00000,
        op_or      = 5'b00001,
        op_xor     = 5'b00010,
        op_not     = 5'b00011,
        op_shftr   = 5'b00100,
        op_shftri  = 5'b00101,                       // Arithmetic right shift
        op_shftl   = 5'b00110,
        op_shftli  = 5'b00111,
        op_br      = 5'b01000,
        op_brr     = 5'b01001,
        op_addi2   = 5'b01010,                       // Second addi encoding
        op_subi2   = 5'b01011,                       // Second subi encoding
        op_brgt    = 5'b01110,
        op_load    = 5'b10000,
        op_mov_rr  = 5'b10001,
        op_mov_lit = 5'b10010,
        op_store   = 5'b10011,
        op_add     = 5'b11000,
        op_addi    = 5'b11001,
        op_sub     = 5'b11010,
        op_subi    = 5'b11011,
        op_mul     = 5'b11100,
        op_div     = 5'b11101,
        op_halt    = 5'b11111
    } opcode_t;

    localparam int OPCODE_LSB = 27;                  // Opcode in [31:27]
    localparam int DEST_LSB   = 22;                  // rd in [26:22]
    localparam int SRC1_LSB   = 17;                  // rs in [21:17]
    localparam int SRC2_LSB   = 12;                  // rt in [16:12]
    localparam int IMM_WIDTH  = 12;                  // Literal in [11:0]

    localparam word_t INSTR_BYTES      = 64'd4;      // Sequential PC step
    localparam word_t RESET_PC_DEFAULT = 64'h2000;   // First fetch address

    // ----------------------------------------------------------
    // Memory port and control strobes
    // ----------------------------------------------------------
    typedef struct packed {
        logic  valid;                                // Request pending
        logic  write;                                // Store when set
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;                                // Accepts request this cycle
        word_t rdata;                                // Valid in the transfer cycle
    } mem_rsp_t;

    typedef struct packed {
        logic ir_load;
        logic alu_load;
        logic mdr_load;
        logic pc_load;
        logic reg_write;
        logic mem_to_reg;                            // Writeback takes loaded data
    } ctrl_t;

    // Opcode classes
    function automatic logic is_load_op(opcode_t op);
        return op == op_load;
    endfunction

    function automatic logic is_store_op(opcode_t op);
        return op == op_store;
    endfunction

    function automatic logic is_branch_op(opcode_t op);
        return op inside {op_br, op_brr, op_brgt};
    endfunction

    function automatic logic uses_immediate(opcode_t op);
        return op inside {op_addi, op_addi2, op_subi, op_subi2, op_shftri, op_shftli,
                          op_mov_lit, op_load, op_store};
    endfunction

    function automatic logic src1_from_dest(opcode_t op);
        return op inside {op_addi, op_addi2, op_subi, op_subi2, op_shftri, op_shftli};
    endfunction

    // Call, return and unknown codes fall outside and write nothing
    function automatic logic writes_register(opcode_t op);
        return op inside {op_add, op_addi, op_addi2, op_sub, op_subi, op_subi2, op_mul,
                          op_div, op_and, op_or, op_xor, op_not, op_shftr, op_shftri,
                          op_shftl, op_shftli, op_mov_rr, op_mov_lit, op_load};
    endfunction

endpackage

/* execute/tinker_alu.sv */
// Integer ALU of the execute stage; picks register or literal operand and computes the result
`timescale 1ns/1ps

module tinker_alu (
    input  tinker_pkg::opcode_t opcode,
    input  tinker_pkg::word_t   src_a,
    input  tinker_pkg::word_t   src_b,
    input  tinker_pkg::word_t   imm,
    output tinker_pkg::word_t   result
);
    import tinker_pkg::*;

    word_t op_b;                                     // Second operand after select

    assign op_b = uses_immediate(opcode) ? imm : src_b;

    always_comb begin
        case (opcode)
            op_add, op_addi, op_addi2: result = src_a + op_b;
            op_sub, op_subi, op_subi2: result = src_a - op_b;
            op_mul:     result = src_a * op_b;
            op_div:     result = (op_b == '0) ? '0 : src_a / op_b;  // Div by zero gives 0
            op_and:     result = src_a & op_b;
            op_or:      result = src_a | op_b;
            op_xor:     result = src_a ^ op_b;
            op_not:     result = ~src_a;
            op_shftr:   result = src_a >> op_b;      // Logical
            op_shftri:  result = $signed(src_a) >>> op_b;  // Keeps sign bit
            op_shftl,
            op_shftli:  result = src_a << op_b;
            op_mov_rr:  result = src_a;
            op_mov_lit: result = op_b;               // Literal straight through
            default:    result = '0;                 // Memory, branch and unknown ops
        endcase
    end

endmodule

/* execute/tinker_branch.sv */
// Branch unit of the execute stage; computes the next PC and whether a branch redirects
`timescale 1ns/1ps

module tinker_branch (
    input  tinker_pkg::opcode_t opcode,
    input  tinker_pkg::word_t   pc,
    input  tinker_pkg::word_t   dest_val,
    input  tinker_pkg::word_t   src_a,
    input  tinker_pkg::word_t   src_b,
    output tinker_pkg::word_t   next_pc,
    output logic                branch_taken
);
    import tinker_pkg::*;

    word_t pc_seq;                                   // Fall-through address

    assign pc_seq = pc + INSTR_BYTES;

    always_comb begin
        next_pc      = pc_seq;
        branch_taken = 1'b0;
        case (opcode)
            op_br: begin
                next_pc      = dest_val;             // Absolute
                branch_taken = 1'b1;
            end
            op_brr: begin
                next_pc      = pc + dest_val;        // PC relative
                branch_taken = 1'b1;
            end
            op_brgt: begin
                if ($signed(src_a) > $signed(src_b)) begin
                    next_pc      = dest_val;
                    branch_taken = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* src/tinker_decoder.sv */
// Instruction field decoder; splits the IR and sign-extends the literal for the datapath
`timescale 1ns/1ps

module tinker_decoder (
    input  tinker_pkg::instr_t    instr,
    output tinker_pkg::opcode_t   opcode,
    output tinker_pkg::reg_addr_t dest,
    output tinker_pkg::reg_addr_t src1,
    output tinker_pkg::reg_addr_t src2,
    output tinker_pkg::word_t     imm
);
    import tinker_pkg::*;

    localparam int RW = $bits(reg_addr_t);           // Register field width

    logic [IMM_WIDTH-1:0] imm_raw;
    reg_addr_t            rs_field;

    assign opcode   = opcode_t'(instr[OPCODE_LSB +: $bits(opcode_t)]);
    assign dest     = instr[DEST_LSB +: RW];
    assign rs_field = instr[SRC1_LSB +: RW];
    assign src2     = instr[SRC2_LSB +: RW];
    assign imm_raw  = instr[IMM_WIDTH-1:0];

    // Immediate ALU forms operate on rd in place
    assign src1 = src1_from_dest(opcode) ? dest : rs_field;

    assign imm = {{(XLEN-IMM_WIDTH){imm_raw[IMM_WIDTH-1]}}, imm_raw};  // Sign extend

endmodule

/* src/tinker_regfile.sv */
// General register file; 32 x 64 bits, async reads for rs, rt and rd, one synchronous write
`timescale 1ns/1ps

module tinker_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write_en,
    input  tinker_pkg::reg_addr_t write_addr,
    input  tinker_pkg::word_t     write_data,
    input  tinker_pkg::reg_addr_t rd_addr1,
    input  tinker_pkg::reg_addr_t rd_addr2,
    output tinker_pkg::word_t     rd_data1,
    output tinker_pkg::word_t     rd_data2,
    output tinker_pkg::word_t     rd_dest
);
    import tinker_pkg::*;

    localparam int NREGS = 2 ** $bits(reg_addr_t);

    word_t regs [NREGS];                             // r0 is writable like any other

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) regs[i] <= '0;
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];
    assign rd_dest  = regs[write_addr];              // rd value for stores and branches

endmodule

/* src/tinker_datapath.sv */
// Datapath of the core; PC, IR, ALU and load registers plus memory address and writeback muxes
`timescale 1ns/1ps

module tinker_datapath #(
    parameter tinker_pkg::word_t RESET_PC = tinker_pkg::RESET_PC_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  tinker_pkg::ctrl_t   ctrl,
    input  logic                mem_is_fetch,
    input  tinker_pkg::word_t   mem_rdata,
    output tinker_pkg::word_t   mem_addr,
    output tinker_pkg::word_t   mem_wdata,
    output tinker_pkg::opcode_t opcode,
    output logic                branch_taken
);
    import tinker_pkg::*;

    word_t     pc;
    word_t     next_pc;
    instr_t    ir;                                   // Instruction register
    word_t     alu_q;                                // ALU result register
    word_t     mdr;                                  // Memory data register
    word_t     alu_result;
    word_t     imm;                                  // Sign-extended literal
    word_t     src1_val;
    word_t     src2_val;
    word_t     dest_val;
    word_t     wb_data;
    reg_addr_t dest;
    reg_addr_t src1;
    reg_addr_t src2;

    // ----------------------------------------------------------
    // State registers
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
            ir <= '0;
        end else begin
            if (ctrl.pc_load) pc <= next_pc;
            if (ctrl.ir_load) ir <= mem_rdata[$bits(instr_t)-1:0];  // Low word is the instruction
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.alu_load) alu_q <= alu_result;
        if (ctrl.mdr_load) mdr <= mem_rdata;
    end

    // PC on fetch, rd + L for store, rs + L for load
    always_comb begin
        if (mem_is_fetch) begin
            mem_addr = pc;
        end else if (is_store_op(opcode)) begin
            mem_addr = dest_val + imm;
        end else begin
            mem_addr = src1_val + imm;
        end
    end

    assign mem_wdata = src1_val;                     // Store data from rs
    assign wb_data   = ctrl.mem_to_reg ? mdr : alu_q;

    tinker_decoder u_decoder (
        .instr (ir),
        .opcode(opcode),
        .dest  (dest),
        .src1  (src1),
        .src2  (src2),
        .imm   (imm)
    );

    tinker_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .write_en  (ctrl.reg_write),
        .write_addr(dest),
        .write_data(wb_data),
        .rd_addr1  (src1),
        .rd_addr2  (src2),
        .rd_data1  (src1_val),
        .rd_data2  (src2_val),
        .rd_dest   (dest_val)
    );

    tinker_alu u_alu (
        .opcode(opcode),
        .src_a (src1_val),
        .src_b (src2_val),
        .imm   (imm),
        .result(alu_result)
    );

    tinker_branch u_branch (
        .opcode      (opcode),
        .pc          (pc),
        .dest_val    (dest_val),
        .src_a       (src1_val),
        .src_b       (src2_val),
        .next_pc     (next_pc),
        .branch_taken(branch_taken)
    );

endmodule

/* control/tinker_control.sv */
// Instruction-cycle FSM of the core; sequences fetch to writeback and owns the memory strobes
`timescale 1ns/1ps

module tinker_control (
    input  logic                clk,
    input  logic                reset,
    input  tinker_pkg::opcode_t opcode,
    input  logic                branch_taken,
    input  logic                mem_ready,
    output tinker_pkg::ctrl_t   ctrl,
    output logic                mem_valid,
    output logic                mem_write,
    output logic                mem_is_fetch,
    output logic                hlt
);
    import tinker_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } state_t;

    state_t state;
    state_t next_state;
    logic   xfer;                                    // Handshake completes
    logic   take_branch;                             // Redirect at end of EXECUTE

    assign xfer        = mem_valid && mem_ready;
    assign take_branch = is_branch_op(opcode) && branch_taken;

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            FETCH: begin
                if (xfer) next_state = DECODE;       // Wait out back-pressure
            end
            DECODE: begin
                next_state = (opcode == op_halt) ? HALTED : EXECUTE;
            end
            EXECUTE: begin
                if (take_branch) begin
                    next_state = FETCH;              // No writeback after taken branch
                end else if (is_load_op(opcode) || is_store_op(opcode)) begin
                    next_state = MEMORY;
                end else begin
                    next_state = WRITEBACK;
                end
            end
            MEMORY: begin
                if (xfer) next_state = WRITEBACK;
            end
            WRITEBACK: next_state = FETCH;
            HALTED:    next_state = HALTED;          // Left only by reset
            default:   next_state = FETCH;
        endcase
    end

    // Request strobes are registered, so they rise with FETCH/MEMORY entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= FETCH;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= next_state;
            mem_valid <= (next_state == FETCH) || (next_state == MEMORY);
            mem_write <= (next_state == MEMORY) && is_store_op(opcode);
        end
    end

    // ----------------------------------------------------------
    // Datapath enables
    // ----------------------------------------------------------
    assign ctrl.ir_load    = (state == FETCH) && xfer;
    assign ctrl.alu_load   = (state == EXECUTE);
    assign ctrl.mdr_load   = (state == MEMORY) && xfer && is_load_op(opcode);
    assign ctrl.pc_load    = ((state == EXECUTE) && take_branch) || (state == WRITEBACK);
    assign ctrl.reg_write  = (state == WRITEBACK) && writes_register(opcode);
    assign ctrl.mem_to_reg = is_load_op(opcode);

    assign mem_is_fetch = (state == FETCH);
    assign hlt          = (state == HALTED);         // One cycle after halt decode

endmodule

/* src/tinker_core.sv */
// Top level of the multicycle core; joins control and datapath onto the external memory port
`timescale 1ns/1ps

module tinker_core #(
    parameter tinker_pkg::word_t RESET_PC = tinker_pkg::RESET_PC_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    output tinker_pkg::mem_req_t mem_req,
    input  tinker_pkg::mem_rsp_t mem_rsp,
    output logic                 hlt
);
    import tinker_pkg::*;

    ctrl_t   ctrl;                                   // FSM enables
    opcode_t opcode;                                 // Decoded from IR
    logic    branch_taken;
    logic    mem_valid;
    logic    mem_write;
    logic    mem_is_fetch;                           // Address comes from PC
    word_t   mem_addr;
    word_t   mem_wdata;

    tinker_control u_control (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .mem_ready    (mem_rsp.ready),
        .ctrl         (ctrl),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_is_fetch (mem_is_fetch),
        .hlt          (hlt)
    );

    tinker_datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .mem_is_fetch (mem_is_fetch),
        .mem_rdata    (mem_rsp.rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .opcode       (opcode),
        .branch_taken (branch_taken)
    );

    // Strobes from the FSM, payload from the datapath
    assign mem_req = '{valid: mem_valid, write: mem_write, addr: mem_addr, wdata: mem_wdata};

endmodule

/* sim/tb_tinker_core.sv */
// Testbench for tinker_core; acts as the memory, runs the program from the cases file, checks stores
`timescale 1ns/1ps

module tb_tinker_core;
    import tinker_pkg::*;

    localparam int HALT_TIMEOUT = 5000;              // Cycles allowed to reach halt
    localparam int QUIET_CYCLES = 40;                // Window after halt with no request

    logic     clk;
    logic     reset;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     hlt;

    logic [7:0]  mem [logic [63:0]];                 // Sparse byte memory
    logic [63:0] exp_addr [$];                       // Expected store sequence
    logic [63:0] exp_data [$];
    int          n_stores;
    logic [31:0] lfsr;
    int          delay;                              // Ready-low cycles still to go
    logic        pending;                            // Request seen, not yet transferred
    logic        seen_first;
    mem_req_t    held;
    logic        data_read;                          // Next read is a load operand
    logic        check_fetch;                        // Last fetch was not a branch
    logic [63:0] fetch_next;                         // Sequential address after last fetch
    logic [63:0] rd_word;
    opcode_t     fetch_op;

    tinker_core #(.RESET_PC(64'h2000)) DUT (
        .clk    (clk),
        .reset  (reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp),
        .hlt    (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Simulation FAILED");
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("Simulation FAILED");
        $display("%s at %0t", msg, $time);
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d    = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        delay = d;                                   // 0 to 3
    endtask

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            if (mem.exists(addr + i)) w[8*i +: 8] = mem[addr + i];   // Little endian
        end
        return w;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [63:0] a;
        logic [63:0] d;
        fd = $fopen("sim/tinker_cases.txt", "r");
        if (fd == 0) fail_run("cannot open the cases file");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s %h %h", kind, a, d) == 3) begin
                if (kind == "P") begin
                    for (int i = 0; i < 4; i++) mem[a + i] = d[8*i +: 8];
                end else if (kind == "D") begin
                    for (int i = 0; i < 8; i++) mem[a + i] = d[8*i +: 8];
                end else if (kind == "S") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // Memory model with random back-pressure
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            mem_rsp.ready <= 1'b0;
            pending = 1'b0;
        end else if (mem_req.valid) begin
            if (!pending) begin
                if (!seen_first) begin                // First request is the reset fetch
                    check_value("first request addr", mem_req.addr, 64'h2000);
                    check_value("first request write", mem_req.write, 0);
                    seen_first = 1'b1;
                end
                held    = mem_req;
                pending = 1'b1;
            end
            check_value("request write held stable", mem_req.write, held.write);
            check_value("request addr held stable", mem_req.addr, held.addr);
            check_value("request wdata held stable", mem_req.wdata, held.wdata);
            if (mem_rsp.ready) begin
                if (mem_req.write) begin
                    if (n_stores >= exp_addr.size()) fail_run("unexpected extra store");
                    check_value("store addr", mem_req.addr, exp_addr[n_stores]);
                    check_value("store data", mem_req.wdata, exp_data[n_stores]);
                    for (int i = 0; i < 8; i++) mem[mem_req.addr + i] = mem_req.wdata[8*i +: 8];
                    n_stores++;
                end else if (!mem.exists(mem_req.addr)) begin
                    fail_run("read from an address that holds no data");
                end else if (data_read) begin
                    data_read = 1'b0;                 // Operand read of a load
                end else begin
                    if (check_fetch) check_value("fetch addr", mem_req.addr, fetch_next);
                    rd_word     = read_word(mem_req.addr);
                    fetch_op    = opcode_t'(rd_word[OPCODE_LSB +: 5]);
                    check_fetch = !(fetch_op inside {op_br, op_brr, op_brgt});  // Target in regs
                    fetch_next  = mem_req.addr + 64'd4;
                    data_read   = (fetch_op == op_load);
                end
                mem_rsp.ready <= 1'b0;
                pending = 1'b0;
                draw_delay();
            end else if (delay == 0) begin
                mem_rsp.ready <= 1'b1;
                mem_rsp.rdata <= read_word(mem_req.addr);  // Valid with ready
            end else begin
                delay--;
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int cycles;
        reset         = 1'b1;
        mem_rsp       = '0;
        n_stores      = 0;
        lfsr          = 32'h1ef8;
        pending       = 1'b0;
        seen_first    = 1'b0;
        held          = '0;
        delay         = 0;
        data_read     = 1'b0;
        check_fetch   = 1'b0;
        fetch_next    = '0;
        load_cases();
        draw_delay();
        @(posedge clk);
        @(negedge clk);
        check_value("hlt in reset", hlt, 0);
        check_value("valid in reset", mem_req.valid, 0);
        check_value("write in reset", mem_req.write, 0);
        @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!hlt) begin                            // Run until halt
            @(negedge clk);
            cycles++;
            if (cycles > HALT_TIMEOUT) fail_run("timeout waiting for hlt");
        end

        cycles = 0;
        while (cycles < QUIET_CYCLES) begin           // Halted core stays silent
            @(negedge clk);
            cycles++;
            check_value("hlt after halt", hlt, 1);
            check_value("valid after halt", mem_req.valid, 0);
        end
        check_value("store count", n_stores, exp_addr.size());

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* sim/tinker_cases.txt */
# P = program word (addr, instr), D = preload (addr, 64-bit data)
# S = expected store in order (addr, data)
P 2000 90400100
P 2004 90800007
P 2008 90C00FFD
P 200c C1043000
P 2010 98480000
P 2014 E1443000
P 2018 984A0008
P 201c E9040000
P 2020 98480010
P 2024 28C00001
P 2028 98460018
P 202c 81C20200
P 2030 11CE5000
P 2034 984E0020
P 2038 9200040A
P 203c 3A000003
P 2040 42000000
P 2044 984401F0
P 2048 984401F8
P 204c 984401E8
P 2050 9240000C
P 2054 4A400000
P 2058 984401E0
P 205c 984401D8
P 2060 72062000
P 2064 CA000024
P 2068 72043000
P 206c 984401D0
P 2070 984401C8
P 2074 D2843000
P 2078 DA800001
P 207c 32D42000
P 2080 98560028
P 2084 23062000
P 2088 1B580000
P 208c 0B5A2000
P 2090 039A3000
P 2094 985C0030
P 2098 8BD80000
P 209c CBC00001
P 20a0 985E0038
P 20a4 F8000000
D 300 0123456789abcdef
S 100 0000000000000004
S 108 FFFFFFFFFFFFFFEB
S 110 0000000000000000
S 118 FFFFFFFFFFFFFFFE
S 120 FEDCBA9876543204
S 128 0000000000000400
S 130 FE00000000000006
S 138 0200000000000000

/* project.f */
common/tinker_pkg.sv
execute/tinker_alu.sv
execute/tinker_branch.sv
src/tinker_decoder.sv
src/tinker_regfile.sv
src/tinker_datapath.sv
control/tinker_control.sv
src/tinker_core.sv
sim/tb_tinker_core.sv

/* Bender.yml */
package:
  name: tinker_core

sources:
  - common/tinker_pkg.sv
  - execute/tinker_alu.sv
  - execute/tinker_branch.sv
  - src/tinker_decoder.sv
  - src/tinker_regfile.sv
  - src/tinker_datapath.sv
  - control/tinker_control.sv
  - src/tinker_core.sv
  - target: simulation
    files:
      - sim/tb_tinker_core.sv
